/* hdl/uart_link_pkg.sv */
// line-level constants of the framed-string UART link
// bit timing, frame delimiter and FIFO sizing
`default_nettype none

package uart_link_pkg;

	// system clocks per serial bit
	localparam int clks_per_bit = 8;

	// '&' opens and closes every frame
	localparam logic [7:0] frame_delim = 8'h26;

	// both FIFOs share one depth
	localparam int fifo_depth = 16;
	localparam int fifo_aw = 4;

endpackage

`default_nettype wire

/* hdl/uart_regs_pkg.sv */
// register map of the UART link Wishbone slave
// addresses, control bits and status bit positions
`default_nettype none

package uart_regs_pkg;

	localparam logic [2:0] reg_ctrl = 3'd0;
	localparam logic [2:0] reg_status = 3'd1;
	localparam logic [2:0] reg_tx_data = 3'd2;
	localparam logic [2:0] reg_rx_data = 3'd3;
	localparam logic [2:0] reg_rx_len = 3'd4;

	// control register bits
	localparam int ctrl_send = 0;
	localparam int ctrl_rx_clear = 1;

	// status register bits
	localparam int st_tx_busy = 0;
	localparam int st_rx_ready = 1;
	localparam int st_rx_error = 2;
	localparam int st_tx_full = 3;
	localparam int st_rx_empty = 4;

endpackage

`default_nettype wire

/* hdl/byte_fifo.sv */
// synchronous byte FIFO with single-cycle flush
// first-word-fall-through read port
`timescale 1ns/1ns
`default_nettype none

module byte_fifo import uart_link_pkg::*; (
	input  wire logic        sys_clk,
	input  wire logic        sys_rst_n,
	input  wire logic        push,
	input  wire logic [7:0]  push_data,
	input  wire logic        pop,
	output logic [7:0]       pop_data,
	input  wire logic        flush,
	output logic             full,
	output logic             empty,
	output logic [fifo_aw:0] count
);

	logic [7:0]         mem [fifo_depth];
	logic [fifo_aw-1:0] wr_ptr;
	logic [fifo_aw-1:0] rd_ptr;
	logic               do_push;
	logic               do_pop;

	assign full = (count == (fifo_aw+1)'(fifo_depth));
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (fifo_aw+1)'(do_push) - (fifo_aw+1)'(do_pop);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
// UART transmitter, 8N1
// shifts one byte out LSB first between a start and a stop bit
`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_link_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic       tx_start,
	input  wire logic [7:0] tx_byte,
	output logic            tx_ready,
	output logic            txd
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

	logic             busy;
	logic [9:0]       shift;
	logic [cnt_w-1:0] clk_cnt;
	logic [3:0]       bit_cnt;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			shift <= '1;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (tx_start) begin
				// stop, data, start; bit 0 leaves first
				busy <= 1'b1;
				shift <= {1'b1, tx_byte, 1'b0};
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (clk_cnt == cnt_last) begin
			clk_cnt <= '0;
			shift <= {1'b1, shift[9:1]};
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// idle line stays high since ones shift in behind the stop bit
	assign txd = shift[0];
	assign tx_ready = !busy;

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
// UART receiver, 8N1
// two-flop input sync, start bit recheck, mid-bit data sampling
`timescale 1ns/1ns
`default_nettype none

module uart_rx import uart_link_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic       rxd,
	output logic [7:0]      rx_byte,
	output logic            rx_valid
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);

	typedef enum logic [1:0] {r_idle, r_start, r_data, r_stop} rx_state_t;

	rx_state_t        state;
	logic [2:0]       sync_q;
	logic             rxd_s;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_cnt;

	// two sync stages, third flop only for edge detection
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			sync_q <= '1;
		else
			sync_q <= {sync_q[1:0], rxd};
	end
	assign rxd_s = sync_q[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= r_idle;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				r_idle: begin
					clk_cnt <= '0;
					if (sync_q[2] && !rxd_s)
						state <= r_start;
				end
				r_start: if (clk_cnt == cnt_half) begin
					// glitch if the line went back high
					clk_cnt <= '0;
					bit_cnt <= '0;
					state <= rxd_s ? r_idle : r_data;
				end
				r_data: if (clk_cnt == cnt_last) begin
					clk_cnt <= '0;
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= r_stop;
				end
				r_stop: if (clk_cnt == cnt_last) begin
					rx_valid <= rxd_s;
					state <= r_idle;
				end
				default: state <= r_idle;
			endcase
		end
	end

	// data shift register, LSB arrives first
	always_ff @(posedge sys_clk) begin
		if (state == r_data && clk_cnt == cnt_last)
			rx_byte <= {rxd_s, rx_byte[7:1]};
	end

endmodule

`default_nettype wire

/* hdl/frame_control.sv */
// frame sender and parser for the &&payload&& string format
// sender drains the transmit FIFO, parser fills the receive FIFO
`timescale 1ns/1ns
`default_nettype none

module frame_control import uart_link_pkg::*; (
	input  wire logic        sys_clk,
	input  wire logic        sys_rst_n,
	input  wire logic        send_start,
	input  wire logic        rx_clear,
	output logic             tx_busy,
	output logic             rx_ready,
	output logic             rx_error,
	output logic [fifo_aw:0] rx_len,
	output logic             txf_pop,
	input  wire logic [7:0]  txf_data,
	input  wire logic        txf_empty,
	output logic             rxf_push,
	output logic [7:0]       rxf_data,
	output logic             rxf_flush,
	input  wire logic        rxf_full,
	output logic             tx_start,
	output logic [7:0]       tx_byte,
	input  wire logic        tx_ready,
	input  wire logic [7:0]  rx_byte,
	input  wire logic        rx_valid
);

	typedef enum logic [2:0] {
		s_idle, s_open1, s_open2, s_payload, s_close1, s_close2
	} send_state_t;

	typedef enum logic [1:0] {p_hunt, p_open2, p_payload, p_close2} parse_state_t;

	send_state_t  sstate;
	parse_state_t pstate;
	logic         want_byte;
	logic         is_delim;
	logic [fifo_aw:0] rx_cnt;

	// byte offered to the serializer in each send state
	always_comb begin
		tx_byte = frame_delim;
		want_byte = 1'b1;
		case (sstate)
			s_idle: want_byte = 1'b0;
			s_payload: begin
				tx_byte = txf_data;
				want_byte = !txf_empty;
			end
			default: ;
		endcase
	end

	assign tx_start = want_byte && tx_ready;
	assign txf_pop = (sstate == s_payload) && tx_start;
	// still busy until the last delimiter has left the serializer
	assign tx_busy = (sstate != s_idle) || !tx_ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sstate <= s_idle;
		end else begin
			case (sstate)
				s_idle: if (send_start) sstate <= s_open1;
				s_open1: if (tx_start) sstate <= s_open2;
				s_open2: if (tx_start) sstate <= s_payload;
				s_payload: if (txf_empty) sstate <= s_close1;
				s_close1: if (tx_start) sstate <= s_close2;
				s_close2: if (tx_start) sstate <= s_idle;
				default: sstate <= s_idle;
			endcase
		end
	end

	assign is_delim = (rx_byte == frame_delim);
	assign rxf_data = rx_byte;
	assign rxf_push = (pstate == p_payload) && rx_valid && !is_delim && !rxf_full;
	// lone closing '&' means the frame is broken
	assign rxf_flush = (pstate == p_close2) && rx_valid && !is_delim;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pstate <= p_hunt;
			rx_cnt <= '0;
			rx_len <= '0;
			rx_ready <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			if (rx_clear) begin
				rx_ready <= 1'b0;
				rx_error <= 1'b0;
			end
			if (rx_valid) begin
				case (pstate)
					p_hunt: if (is_delim) pstate <= p_open2;
					p_open2: begin
						rx_cnt <= '0;
						pstate <= is_delim ? p_payload : p_hunt;
					end
					p_payload: begin
						if (is_delim)
							pstate <= p_close2;
						else if (rxf_full)
							rx_error <= 1'b1;
						else
							rx_cnt <= rx_cnt + 1'b1;
					end
					p_close2: begin
						if (is_delim) begin
							rx_len <= rx_cnt;
							rx_ready <= 1'b1;
						end else begin
							rx_error <= 1'b1;
						end
						pstate <= p_hunt;
					end
					default: pstate <= p_hunt;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/uart_wb_regs.sv */
// Wishbone classic register block of the UART link
// single-cycle ack, FIFO push/pop strobes, control pulses, status
`timescale 1ns/1ns
`default_nettype none

module uart_wb_regs import uart_link_pkg::*, uart_regs_pkg::*; (
	input  wire logic             sys_clk,
	input  wire logic             sys_rst_n,
	input  wire logic             wb_cyc,
	input  wire logic             wb_stb,
	input  wire logic             wb_we,
	input  wire logic [2:0]       wb_adr,
	input  wire logic [7:0]       wb_dat_w,
	output logic      [7:0]       wb_dat_r,
	output logic                  wb_ack,
	output logic                  send_start,
	output logic                  rx_clear,
	input  wire logic             tx_busy,
	input  wire logic             rx_ready,
	input  wire logic             rx_error,
	input  wire logic [fifo_aw:0] rx_len,
	output logic                  txf_push,
	output logic      [7:0]       txf_data,
	input  wire logic             txf_full,
	output logic                  rxf_pop,
	input  wire logic [7:0]       rxf_data,
	input  wire logic             rxf_empty
);

	logic       acc;
	logic       wr;
	logic       rd;
	logic [7:0] status;
	logic [7:0] rd_mux;

	// one access per strobe, ack blocks the second cycle
	assign acc = wb_cyc && wb_stb && !wb_ack;
	assign wr = acc && wb_we;
	assign rd = acc && !wb_we;

	assign send_start = wr && (wb_adr == reg_ctrl) && wb_dat_w[ctrl_send] && !tx_busy;
	assign rx_clear = wr && (wb_adr == reg_ctrl) && wb_dat_w[ctrl_rx_clear];
	assign txf_push = wr && (wb_adr == reg_tx_data) && !txf_full;
	assign txf_data = wb_dat_w;
	assign rxf_pop = rd && (wb_adr == reg_rx_data) && !rxf_empty;

	always_comb begin
		status = '0;
		status[st_tx_busy] = tx_busy;
		status[st_rx_ready] = rx_ready;
		status[st_rx_error] = rx_error;
		status[st_tx_full] = txf_full;
		status[st_rx_empty] = rxf_empty;
	end

	always_comb begin
		case (wb_adr)
			reg_status: rd_mux = status;
			reg_rx_data: rd_mux = rxf_empty ? 8'h00 : rxf_data;
			reg_rx_len: rd_mux = 8'(rx_len);
			default: rd_mux = 8'h00;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= acc;
	end

	// read data held while ack is high
	always_ff @(posedge sys_clk) begin
		if (rd)
			wb_dat_r <= rd_mux;
	end

endmodule

`default_nettype wire

/* hdl/uart_frame_top.sv */
// framed-string UART link top level
// Wishbone register block, transmit and receive FIFOs, frame controller, UART
`timescale 1ns/1ns
`default_nettype none

module uart_frame_top (
	input  wire logic       sys_clk,
	input  wire logic       sys_rst_n,
	input  wire logic       wb_cyc,
	input  wire logic       wb_stb,
	input  wire logic       wb_we,
	input  wire logic [2:0] wb_adr,
	input  wire logic [7:0] wb_dat_w,
	output logic      [7:0] wb_dat_r,
	output logic            wb_ack,
	output logic            irq,
	input  wire logic       uart_rxd,
	output logic            uart_txd
);

	logic       send_start;
	logic       rx_clear;
	logic       tx_busy;
	logic       rx_ready;
	logic       rx_error;
	logic [4:0] rx_len;
	logic       txf_push;
	logic [7:0] txf_wdata;
	logic       txf_full;
	logic       txf_pop;
	logic [7:0] txf_rdata;
	logic       txf_empty;
	logic       rxf_push;
	logic [7:0] rxf_wdata;
	logic       rxf_flush;
	logic       rxf_full;
	logic       rxf_pop;
	logic [7:0] rxf_rdata;
	logic       rxf_empty;
	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_ready;
	logic [7:0] rx_byte;
	logic       rx_valid;

	assign irq = rx_ready;

	uart_wb_regs regs0 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.send_start (send_start),
		.rx_clear   (rx_clear),
		.tx_busy    (tx_busy),
		.rx_ready   (rx_ready),
		.rx_error   (rx_error),
		.rx_len     (rx_len),
		.txf_push   (txf_push),
		.txf_data   (txf_wdata),
		.txf_full   (txf_full),
		.rxf_pop    (rxf_pop),
		.rxf_data   (rxf_rdata),
		.rxf_empty  (rxf_empty)
	);

	// transmit side is never flushed
	byte_fifo tx_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.push      (txf_push),
		.push_data (txf_wdata),
		.pop       (txf_pop),
		.pop_data  (txf_rdata),
		.flush     (1'b0),
		.full      (txf_full),
		.empty     (txf_empty),
		.count     ()
	);

	byte_fifo rx_fifo (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.push      (rxf_push),
		.push_data (rxf_wdata),
		.pop       (rxf_pop),
		.pop_data  (rxf_rdata),
		.flush     (rxf_flush),
		.full      (rxf_full),
		.empty     (rxf_empty),
		.count     ()
	);

	frame_control ctrl0 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.send_start (send_start),
		.rx_clear   (rx_clear),
		.tx_busy    (tx_busy),
		.rx_ready   (rx_ready),
		.rx_error   (rx_error),
		.rx_len     (rx_len),
		.txf_pop    (txf_pop),
		.txf_data   (txf_rdata),
		.txf_empty  (txf_empty),
		.rxf_push   (rxf_push),
		.rxf_data   (rxf_wdata),
		.rxf_flush  (rxf_flush),
		.rxf_full   (rxf_full),
		.tx_start   (tx_start),
		.tx_byte    (tx_byte),
		.tx_ready   (tx_ready),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid)
	);

	uart_tx tx0 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte),
		.tx_ready  (tx_ready),
		.txd       (uart_txd)
	);

	uart_rx rx0 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rxd       (uart_rxd),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid)
	);

endmodule

`default_nettype wire

/* test/uart_frame_checker.sv */
// bus read checker of the UART link testbench
// compares every checked Wishbone read with the expected value under a mask
`timescale 1ns/1ns
`default_nettype none

module uart_frame_checker import uart_regs_pkg::*; (
	input  wire logic       sys_clk,
	input  wire logic       wb_ack,
	input  wire logic       wb_we,
	input  wire logic [2:0] wb_adr,
	input  wire logic [7:0] wb_dat_r,
	input  wire logic [7:0] exp_data,
	input  wire logic [7:0] exp_mask,
	output int              err_count
);

	function automatic string reg_name(input logic [2:0] adr);
		case (adr)
			reg_ctrl: return "ctrl";
			reg_status: return "status";
			reg_tx_data: return "tx_data";
			reg_rx_data: return "rx_data";
			reg_rx_len: return "rx_len";
			default: return "unmapped";
		endcase
	endfunction

	initial begin
		err_count = 0;
	end

	// read data sits still at the falling edge inside the ack cycle
	always @(negedge sys_clk) begin
		if (wb_ack && !wb_we && exp_mask != 8'h00) begin
			if ((wb_dat_r & exp_mask) !== (exp_data & exp_mask)) begin
				err_count++;
				$display("Fail %0t wb_dat_r (%s): expected %02h, got %02h, mask %02h",
					$time, reg_name(wb_adr), exp_data & exp_mask,
					wb_dat_r & exp_mask, exp_mask);
			end
		end
	end

endmodule

`default_nettype wire

/* test/uart_frame_asserts.sv */
// concurrent checks on the UART link top level
// bus ack shape, idle line level and interrupt clear
`timescale 1ns/1ns
`default_nettype none

module uart_frame_asserts (
	input  wire logic sys_clk,
	input  wire logic sys_rst_n,
	input  wire logic wb_cyc,
	input  wire logic wb_stb,
	input  wire logic wb_ack,
	input  wire logic tx_busy,
	input  wire logic rx_clear,
	input  wire logic irq,
	input  wire logic uart_txd
);

	int fail_count = 0;

	ack_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb_ack |=> !wb_ack)
	else begin
		fail_count++;
		$error("wb_ack stayed high for more than one cycle");
	end

	// ack only answers an active strobe
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
	else begin
		fail_count++;
		$error("wb_ack outside a cycle with wb_cyc and wb_stb");
	end

	line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_txd)
	else begin
		fail_count++;
		$error("uart_txd low while the sender is idle");
	end

	irq_clear: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_clear |=> !irq)
	else begin
		fail_count++;
		$error("irq still high after a status clear");
	end

endmodule

`default_nettype wire

/* test/uart_frame_tb.sv */
// testbench of the framed-string UART link
// Wishbone tasks, loopback and serial stimulus, line sampling, watchdog
`timescale 1ns/1ns
`default_nettype none

module uart_frame_tb import uart_link_pkg::*, uart_regs_pkg::*; ();

	localparam logic [7:0] send_cmd = 8'(1 << ctrl_send);
	localparam logic [7:0] clear_cmd = 8'(1 << ctrl_rx_clear);
	// longest frames of the loopback, line, malformed and overflow tests
	localparam int frame_bytes = 16 + 16 + 5 + 20;
	localparam longint watchdog_ns = 2 * frame_bytes * 10 * clks_per_bit * 8;

	logic        sys_clk;
	logic        sys_rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [7:0]  wb_dat_w;
	logic [7:0]  wb_dat_r;
	logic        wb_ack;
	logic        irq;
	logic        uart_rxd;
	logic        uart_txd;
	logic        loop_en;
	logic        ser_rxd;
	logic [7:0]  exp_data;
	logic [7:0]  exp_mask;
	logic [31:0] lfsr_state;
	logic [7:0]  payload [0:16];
	logic [7:0]  exp_frame [0:19];
	logic [7:0]  exp_rx [0:15];
	int          exp_len;
	int          tb_errors;
	int          bus_errors;

	// txd back into rxd, or the serial driver
	assign uart_rxd = loop_en ? uart_txd : ser_rxd;

	uart_frame_top dut0 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.irq       (irq),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd)
	);

	uart_frame_checker chk0 (
		.sys_clk   (sys_clk),
		.wb_ack    (wb_ack),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_r  (wb_dat_r),
		.exp_data  (exp_data),
		.exp_mask  (exp_mask),
		.err_count (bus_errors)
	);

	bind uart_frame_top uart_frame_asserts asserts0 (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_ack    (wb_ack),
		.tx_busy   (tx_busy),
		.rx_clear  (rx_clear),
		.irq       (irq),
		.uart_txd  (uart_txd)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	initial begin
		#(watchdog_ns);
		$display("run timed out after %0d ns", watchdog_ns);
		$display("test failed");
		$finish;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	task automatic make_payload(input int n);
		int i;
		logic [7:0] b;
		for (i = 0; i < n; i++) begin
			random_bits(8, b);
			// no delimiter inside a payload
			payload[i] = (b == frame_delim) ? 8'h41 : b;
		end
	endtask

	// expected line bytes and receive FIFO contents for n written bytes
	function automatic int build_reference(input int n);
		int k;
		exp_len = (n > fifo_depth) ? fifo_depth : n;
		for (k = 0; k < exp_len + 4; k++) begin
			if (k < 2 || k >= exp_len + 2)
				exp_frame[k] = frame_delim;
			else
				exp_frame[k] = payload[k - 2];
		end
		for (k = 0; k < exp_len; k++)
			exp_rx[k] = payload[k];
		return exp_len + 4;
	endfunction

	task automatic bus_access(input logic we, input logic [2:0] adr, input logic [7:0] wdata,
			input logic [7:0] exp_val, input logic [7:0] mask, output logic [7:0] rdata);
		int n;
		@(negedge sys_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		exp_data <= exp_val;
		exp_mask <= mask;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!wb_ack && n < 16);
		if (!wb_ack) begin
			$display("no wb_ack for an access to register %0d", adr);
			tb_errors++;
		end
		rdata = wb_dat_r;
		// strobe drops after the ack cycle has closed
		@(negedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [7:0] d);
		logic [7:0] unused;
		bus_access(1'b1, adr, d, 8'h00, 8'h00, unused);
	endtask

	task automatic check_reg(input logic [2:0] adr, input logic [7:0] exp_val,
			input logic [7:0] mask);
		logic [7:0] d;
		bus_access(1'b0, adr, 8'h00, exp_val, mask, d);
	endtask

	task automatic wait_tx_idle();
		logic [7:0] st;
		int polls;
		polls = 0;
		do begin
			bus_access(1'b0, reg_status, 8'h00, 8'h00, 8'h00, st);
			polls++;
		end while (st[st_tx_busy] && polls < 2000);
		if (st[st_tx_busy]) begin
			$display("tx_busy never fell while polling status");
			tb_errors++;
		end
	endtask

	task automatic send_payload(input int n);
		int i;
		for (i = 0; i < n; i++)
			write_reg(reg_tx_data, payload[i]);
		write_reg(reg_ctrl, send_cmd);
	endtask

	task automatic verify_loopback();
		int k;
		wait_tx_idle();
		if (irq !== 1'b1) begin
			$display("Fail %0t irq: expected 1, got %b", $time, irq);
			tb_errors++;
		end
		// idle, frame ready, no error, data waiting
		check_reg(reg_status, 8'h02, 8'h17);
		check_reg(reg_rx_len, 8'(exp_len), 8'hff);
		for (k = 0; k < exp_len; k++)
			check_reg(reg_rx_data, exp_rx[k], 8'hff);
		check_reg(reg_rx_data, 8'h00, 8'hff);
		write_reg(reg_ctrl, clear_cmd);
	endtask

	// mid-bit sampling of one 8N1 byte on uart_txd
	task automatic sample_txd_byte(output logic [7:0] b, output logic ok);
		int n;
		int i;
		ok = 1'b1;
		b = '0;
		n = 0;
		while (uart_txd && n < 40 * clks_per_bit) begin
			@(negedge sys_clk);
			n++;
		end
		repeat (clks_per_bit / 2) @(negedge sys_clk);
		if (uart_txd)
			ok = 1'b0;
		for (i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge sys_clk);
			b[i] = uart_txd;
		end
		repeat (clks_per_bit) @(negedge sys_clk);
		if (!uart_txd)
			ok = 1'b0;
	endtask

	task automatic serial_send(input logic [7:0] b);
		int i;
		@(negedge sys_clk);
		ser_rxd <= 1'b0;
		repeat (clks_per_bit) @(negedge sys_clk);
		for (i = 0; i < 8; i++) begin
			ser_rxd <= b[i];
			repeat (clks_per_bit) @(negedge sys_clk);
		end
		// stop bit and one idle bit
		ser_rxd <= 1'b1;
		repeat (2 * clks_per_bit) @(negedge sys_clk);
	endtask

	initial begin
		int n;
		int k;
		int flen;
		int asrt_errors;
		logic [7:0] v;
		logic [7:0] b;
		logic ok;
		sys_rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		exp_data = '0;
		exp_mask = '0;
		loop_en = 1'b1;
		ser_rxd = 1'b1;
		lfsr_state = 32'h9b75;
		tb_errors = 0;
		repeat (4) @(negedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);

		// reset state
		check_reg(reg_status, 8'h10, 8'h1b);
		if (irq !== 1'b0) begin
			$display("Fail %0t irq: expected 0, got %b", $time, irq);
			tb_errors++;
		end
		if (uart_txd !== 1'b1) begin
			$display("Fail %0t uart_txd: expected 1, got %b", $time, uart_txd);
			tb_errors++;
		end

		// random payload through the loopback
		random_bits(4, v);
		n = int'(v % 12) + 1;
		make_payload(n);
		flen = build_reference(n);
		send_payload(n);
		verify_loopback();

		// line format with the loopback open
		loop_en <= 1'b0;
		random_bits(4, v);
		n = int'(v % 12) + 1;
		make_payload(n);
		flen = build_reference(n);
		send_payload(n);
		for (k = 0; k < flen; k++) begin
			sample_txd_byte(b, ok);
			if (!ok) begin
				$display("uart_txd byte %0d has a bad start or stop bit", k);
				tb_errors++;
			end else if (b !== exp_frame[k]) begin
				$display("Fail %0t uart_txd byte %0d: expected %02h, got %02h",
					$time, k, exp_frame[k], b);
				tb_errors++;
			end
		end
		wait_tx_idle();

		// broken closing pair
		serial_send(frame_delim);
		serial_send(frame_delim);
		serial_send(8'h78);
		serial_send(frame_delim);
		serial_send(8'h79);
		check_reg(reg_status, 8'h14, 8'h16);
		write_reg(reg_ctrl, clear_cmd);
		check_reg(reg_status, 8'h10, 8'h16);

		// 17 writes into a 16-entry transmit FIFO
		make_payload(17);
		flen = build_reference(17);
		for (k = 0; k < 16; k++)
			write_reg(reg_tx_data, payload[k]);
		check_reg(reg_status, 8'h08, 8'h08);
		write_reg(reg_tx_data, payload[16]);
		check_reg(reg_status, 8'h08, 8'h08);
		loop_en <= 1'b1;
		write_reg(reg_ctrl, send_cmd);
		verify_loopback();

		repeat (4) @(negedge sys_clk);
		asrt_errors = dut0.asserts0.fail_count;
		$display("errors: bus reads %0d, line and flags %0d, assertions %0d",
			bus_errors, tb_errors, asrt_errors);
		if (bus_errors + tb_errors + asrt_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* uart_frame_top.f */
hdl/uart_link_pkg.sv
hdl/uart_regs_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/frame_control.sv
hdl/uart_wb_regs.sv
hdl/uart_frame_top.sv
test/uart_frame_checker.sv
test/uart_frame_asserts.sv
test/uart_frame_tb.sv

/* Bender.yml */
package:
  name: uart_frame_link

sources:
  - files:
      - hdl/uart_link_pkg.sv
      - hdl/uart_regs_pkg.sv
      - hdl/byte_fifo.sv
      - hdl/uart_tx.sv
      - hdl/uart_rx.sv
      - hdl/frame_control.sv
      - hdl/uart_wb_regs.sv
      - hdl/uart_frame_top.sv
  - target: test
    files:
      - test/uart_frame_checker.sv
      - test/uart_frame_asserts.sv
      - test/uart_frame_tb.sv
